// File: common/uart_pkg.sv
package uart_pkg;

    // System clock and line rate
    localparam int CLOCK_FREQ = 33_000_000;
    localparam int BAUD_RATE  = 1_000_000;

    // Clock cycles in one symbol on the line
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

    // Sample the line in the middle of each symbol
    localparam int SAMPLE_POINT = CLKS_PER_BIT / 2;

    // Cycle counter must reach CLKS_PER_BIT - 1
    localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);

    // 8N1: start bit, eight data bits, stop bit
    localparam int FRAME_BITS = 10;

    // Transmitter FSM
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

endpackage

// File: common/fifo_pkg.sv
package fifo_pkg;

    // Entries in the echo buffer
    localparam int FIFO_DEPTH = 4;

    // Pointer width, wraps naturally at FIFO_DEPTH
    localparam int PTR_W = 2;

    // One byte of serial payload
    typedef logic [7:0] byte_t;

endpackage

// File: uart/uart_receiver.sv
module uart_receiver
    import uart_pkg::*, fifo_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  serial_in,
    output byte_t rx_data,
    output logic  rx_valid,
    input  logic  rx_ready,
    output logic  rx_overrun
);

    logic [CLK_CNT_W-1:0] clock_counter;
    logic [3:0]           bit_counter;
    logic [9:0]           rx_shift;
    logic                 has_byte;
    logic                 rx_running;
    logic                 symbol_edge;
    logic                 sample;
    logic                 frame_done;
    logic                 start;

    // Frame in progress while symbols remain
    assign rx_running = bit_counter != 4'd0;

    // Last cycle of a symbol
    assign symbol_edge = clock_counter == CLK_CNT_W'(CLKS_PER_BIT - 1);

    // Middle of a symbol
    assign sample = clock_counter == CLK_CNT_W'(SAMPLE_POINT);

    // Stop symbol closes one cycle early
    // The start bit is seen one cycle late, so this lines up with the line
    // and back to back frames do not drift
    assign frame_done = rx_running && (bit_counter == 4'd1)
                        && (clock_counter == CLK_CNT_W'(CLKS_PER_BIT - 2));

    // Low level on an idle line
    assign start = !serial_in && !rx_running;

    // Data bits sit between start and stop in the shift register
    assign rx_data  = rx_shift[8:1];
    assign rx_valid = has_byte;

    // Symbol timing, restarted by every start bit
    always_ff @(posedge clk) begin
        if (reset || start || symbol_edge) begin
            clock_counter <= '0;
        end else begin
            clock_counter <= clock_counter + 1'b1;
        end
    end

    // Counts down the symbols of one frame
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_counter <= 4'd0;
        end else if (start) begin
            bit_counter <= 4'(FRAME_BITS);
        end else if (frame_done) begin
            bit_counter <= 4'd0;
        end else if (symbol_edge && rx_running) begin
            bit_counter <= bit_counter - 4'd1;
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample && rx_running) begin
            rx_shift <= {serial_in, rx_shift[9:1]};
        end
    end

    // Held byte
    // A new start bit drops it, whether or not it was taken that cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            has_byte <= 1'b0;
        end else if (frame_done) begin
            has_byte <= 1'b1;
        end else if (start || rx_ready) begin
            has_byte <= 1'b0;
        end
    end

    // Sticky, a held byte was lost to the next frame
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_overrun <= 1'b0;
        end else if (start && has_byte && !rx_ready) begin
            rx_overrun <= 1'b1;
        end
    end

endmodule

// File: uart/uart_transmitter.sv
module uart_transmitter
    import uart_pkg::*, fifo_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    input  logic  tx_pause,
    output logic  serial_out
);

    tx_state_t            state;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    byte_t                tx_byte;
    logic                 bit_end;
    logic                 take;

    // Only accept a byte between frames, and not while paused
    assign tx_ready = (state == IDLE) && !tx_pause;
    assign take     = tx_valid && tx_ready;

    // Last cycle of the current symbol
    assign bit_end = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);

    // Byte being sent
    always_ff @(posedge clk) begin
        if (take) begin
            tx_byte <= tx_data;
        end
    end

    // Symbol timing, idle between frames
    always_ff @(posedge clk) begin
        if (reset || state == IDLE || bit_end) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // FSM and registered line output
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            bit_idx    <= 3'd0;
            serial_out <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    serial_out <= 1'b1;
                    if (take) begin
                        state      <= START;
                        serial_out <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state      <= DATA;
                        bit_idx    <= 3'd0;
                        serial_out <= tx_byte[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state      <= STOP;
                            serial_out <= 1'b1;
                        end else begin
                            bit_idx    <= bit_idx + 3'd1;
                            serial_out <= tx_byte[bit_idx + 3'd1];
                        end
                    end
                end
                // Line already high, just hold it one symbol
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/byte_fifo.sv
module byte_fifo
    import fifo_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output byte_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // Ready is simply not full
    assign in_ready  = count != (PTR_W + 1)'(FIFO_DEPTH);
    assign out_valid = count != '0;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Head of the queue is always on the output
    assign out_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap at the depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    // push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/uart_echo_top.sv
module uart_echo_top
    import fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic serial_in,
    input  logic tx_pause,
    output logic serial_out,
    output logic rx_overrun
);

    // Receiver to FIFO
    byte_t rx_data;
    logic  rx_valid;
    logic  rx_ready;

    // FIFO to transmitter
    byte_t fifo_data;
    logic  fifo_valid;
    logic  tx_ready;

    uart_receiver u_receiver (
        .clk        (clk),
        .reset      (reset),
        .serial_in  (serial_in),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_overrun (rx_overrun)
    );

    byte_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (rx_data),
        .in_valid  (rx_valid),
        .in_ready  (rx_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (tx_ready)
    );

    uart_transmitter u_transmitter (
        .clk        (clk),
        .reset      (reset),
        .tx_data    (fifo_data),
        .tx_valid   (fifo_valid),
        .tx_ready   (tx_ready),
        .tx_pause   (tx_pause),
        .serial_out (serial_out)
    );

endmodule

// File: tb/uart_echo_properties.sv
module uart_echo_properties
    import fifo_pkg::*;
(
    input logic           clk,
    input logic           reset,
    input logic           serial_in,
    input logic           serial_out,
    input logic           rx_valid,
    input logic           rx_ready,
    input logic           fifo_valid,
    input logic           tx_ready,
    input logic [PTR_W:0] fifo_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // Line idles high through reset and the cycle after
    assert property (@(posedge clk) reset |=> serial_out)
        else $error("serial_out low during or right after reset");

    // Held byte leaves by a handshake or is dropped by a new start bit
    assert property (@(posedge clk) disable iff (reset)
        $fell(rx_valid) |-> $past(rx_ready) || !$past(serial_in))
        else $error("rx_valid fell without a handshake or a start bit");

    assert property (@(posedge clk) disable iff (reset)
        $fell(fifo_valid) |-> $past(tx_ready))
        else $error("fifo_valid fell without a handshake");

    // A push into a full FIFO would carry the occupancy past its depth
    assert property (@(posedge clk) disable iff (reset)
        fifo_count <= (PTR_W + 1)'(FIFO_DEPTH))
        else $error("FIFO occupancy above its depth");

endmodule

bind uart_echo_top uart_echo_properties u_properties (
    .clk        (clk),
    .reset      (reset),
    .serial_in  (serial_in),
    .serial_out (serial_out),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .fifo_valid (fifo_valid),
    .tx_ready   (tx_ready),
    .fifo_count (u_fifo.count)
);

// File: tb/tb_uart_echo.sv
module tb_uart_echo
    import uart_pkg::*, fifo_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT;

    logic clk;
    logic reset;
    logic serial_in;
    logic tx_pause;
    logic serial_out;
    logic rx_overrun;

    int    errors;
    int    checks;
    int    frames_started;
    // Expected echo, decoded echo and the start time of each echoed frame
    byte_t exp_q[$];
    byte_t got_q[$];
    time   start_q[$];

    uart_echo_top UUT (
        .clk        (clk),
        .reset      (reset),
        .serial_in  (serial_in),
        .tx_pause   (tx_pause),
        .serial_out (serial_out),
        .rx_overrun (rx_overrun)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Advance n rising edges, then settle just past the edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        step(3);
        reset = 1'b0;
    endtask

    // 8N1 frame sent LSB first with one symbol per CLKS_PER_BIT cycles
    task automatic send_byte(input byte_t b);
        logic [FRAME_BITS-1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            serial_in = frame[0];
            frame = {1'b1, frame[FRAME_BITS-1:1]};
            step(CLKS_PER_BIT);
        end
    endtask

    // Pops n echoed bytes and compares them in order
    // Every echoed frame must start after t_after unless it is zero
    task automatic expect_bytes(input int n, input time t_after);
        int    waited;
        byte_t got;
        byte_t exp;
        time   t_start;
        waited = 0;
        while (got_q.size() < n && waited < (n + 2) * FRAME_CYCLES) begin
            step(1);
            waited++;
        end
        if (got_q.size() < n) begin
            errors++;
            $display("Timed out waiting for %0d echoed bytes, only %0d arrived",
                     n, got_q.size());
            got_q.delete();
            exp_q.delete();
            start_q.delete();
        end else begin
            for (int i = 0; i < n; i++) begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                t_start = start_q.pop_front();
                checks++;
                if (got !== exp) begin
                    errors++;
                    $display("ERR serial_out byte %0d: expected %h, got %h", i, exp, got);
                end
                if (t_after != 0) begin
                    checks++;
                    if (t_start <= t_after) begin
                        errors++;
                        $display("Echoed frame began at %0t before input frame end at %0t",
                                 t_start, t_after);
                    end
                end
            end
        end
    endtask

    // Line idle and no overrun for a while after reset
    task automatic test_reset_state();
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            checks++;
            if (serial_out !== 1'b1) begin
                errors++;
                $display("ERR serial_out: expected 1, got %h", serial_out);
            end
            checks++;
            if (rx_overrun !== 1'b0) begin
                errors++;
                $display("ERR rx_overrun: expected 0, got %h", rx_overrun);
            end
        end
        step(1);
    endtask

    task automatic test_single_echo();
        byte_t vals[$];
        time   t_end;
        vals = {8'h55, 8'h00, 8'hFF, 8'hA5};
        foreach (vals[i]) begin
            exp_q.push_back(vals[i]);
            send_byte(vals[i]);
            t_end = $time;
            expect_bytes(1, t_end);
        end
    endtask

    // Input frames are one cycle shorter than echoed ones so the FIFO takes up the slack
    task automatic test_stream_echo();
        byte_t b;
        for (int i = 0; i < 20; i++) begin
            b = 8'($urandom);
            exp_q.push_back(b);
            send_byte(b);
        end
        expect_bytes(20, 64'd0);
        checks++;
        if (rx_overrun !== 1'b0) begin
            errors++;
            $display("ERR rx_overrun: expected 0, got %h", rx_overrun);
        end
    endtask

    // Burst of n bytes while the transmitter is paused
    task automatic paused_burst(input int n);
        byte_t b;
        byte_t held;
        logic  have_held;
        logic  exp_overrun;
        int    base;
        held = '0;
        have_held = 1'b0;
        exp_overrun = 1'b0;
        base = frames_started;
        tx_pause = 1'b1;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom);
            send_byte(b);
            // FIFO fills first and then the receiver holds one byte
            if (i < FIFO_DEPTH) begin
                exp_q.push_back(b);
            end else begin
                // A held byte is lost to the next frame
                if (have_held) begin
                    exp_overrun = 1'b1;
                end
                held = b;
                have_held = 1'b1;
            end
        end
        if (have_held) begin
            exp_q.push_back(held);
        end
        step(2);
        checks++;
        if (frames_started != base || serial_out !== 1'b1) begin
            errors++;
            $display("Transmitter sent a frame while tx_pause was high");
        end
        checks++;
        if (rx_overrun !== exp_overrun) begin
            errors++;
            $display("ERR rx_overrun: expected %h, got %h", exp_overrun, rx_overrun);
        end
        tx_pause = 1'b0;
        expect_bytes(exp_q.size(), 64'd0);
    endtask

    task automatic test_pause_mid_frame();
        byte_t first;
        byte_t second;
        int    base;
        int    waited;
        first = 8'($urandom);
        second = 8'($urandom);
        exp_q.push_back(first);
        exp_q.push_back(second);
        base = frames_started;
        fork
            begin
                send_byte(first);
                send_byte(second);
            end
            begin
                waited = 0;
                while (frames_started == base && waited < 2 * FRAME_CYCLES) begin
                    step(1);
                    waited++;
                end
                if (frames_started == base) begin
                    errors++;
                    $display("Timed out waiting for the first echoed frame to start");
                end
                // A few symbols into the echoed frame
                step(3 * CLKS_PER_BIT);
                tx_pause = 1'b1;
            end
        join
        expect_bytes(1, 64'd0);
        // Second byte waits in the FIFO and the line stays idle
        waited = 0;
        while (frames_started == base + 1 && waited < 2 * FRAME_CYCLES) begin
            step(1);
            waited++;
        end
        checks++;
        if (frames_started != base + 1) begin
            errors++;
            $display("A new frame started on serial_out while tx_pause was high");
        end
        tx_pause = 1'b0;
        expect_bytes(1, 64'd0);
    endtask

    // Decodes serial_out by sampling on falling clock edges mid-symbol
    initial begin : serial_monitor
        logic  prev;
        byte_t b;
        prev = 1'b1;
        b = '0;
        forever begin
            @(negedge clk);
            if (!reset && prev && !serial_out) begin
                frames_started++;
                start_q.push_back($time);
                repeat (SAMPLE_POINT - 1) @(negedge clk);
                if (serial_out !== 1'b0) begin
                    errors++;
                    $display("Start bit on serial_out ended before mid-symbol");
                end
                // LSB first so shift in from the top
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b = {serial_out, b[7:1]};
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                checks++;
                if (serial_out !== 1'b1) begin
                    errors++;
                    $display("ERR serial_out stop bit: expected 1, got %h", serial_out);
                end
                got_q.push_back(b);
            end
            prev = serial_out;
        end
    end

    initial begin
        void'($urandom(25743));
        serial_in = 1'b1;
        tx_pause  = 1'b0;
        apply_reset();
        test_reset_state();
        test_single_echo();
        test_stream_echo();
        // Back-pressure with the fifth byte held in the receiver
        paused_burst(FIFO_DEPTH + 1);
        // Overrun where the sixth byte replaces the fifth
        paused_burst(FIFO_DEPTH + 2);
        test_pause_mid_frame();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
common/uart_pkg.sv
common/fifo_pkg.sv
uart/uart_receiver.sv
uart/uart_transmitter.sv
src/byte_fifo.sv
src/uart_echo_top.sv
tb/uart_echo_properties.sv
tb/tb_uart_echo.sv

// File: Makefile
# Verilator build and run for the UART echo testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_echo
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
